// File: bench/rdp_ref_model.sv
// ******************************
// Cycle model of the read datapath for the testbench
// Predicts valid, data and OCT outputs from the timing rules
// ******************************

`timescale 1ns/1ps
`default_nettype none

module rdp_ref_model #(
	parameter int READ_FIFO_DEPTH = 16,
	parameter int MEM_T_RL        = 11
) (
	input  wire                                    pll_afi_clk,
	input  wire                                    reset_n_afi_clk,
	input  wire rdp_pkg::afi_read_req_t            afi_read_req_i,
	input  wire rdp_pkg::seq_read_ctrl_t           seq_read_ctrl_i,
	input  wire  [rdp_pkg::AFI_DATA_WIDTH-1:0]     ddio_phy_dq_i,
	output logic [rdp_pkg::AFI_DATA_WIDTH-1:0]     exp_rdata_o,
	output logic [rdp_pkg::AFI_RATE_RATIO-1:0]     exp_valid_o,
	output logic [rdp_pkg::AFI_DATA_WIDTH-1:0]     exp_fifo_q_o,
	output logic [rdp_pkg::MEM_READ_DQS_WIDTH-1:0] exp_oct_o
);

	localparam int NG        = rdp_pkg::MEM_READ_DQS_WIDTH;
	localparam int GW        = rdp_pkg::GROUP_DATA_WIDTH;
	localparam int DW        = rdp_pkg::DQ_GROUP_WIDTH;
	localparam int OCT_ON    = (MEM_T_RL - 4) / 2;
	localparam int OCT_OFF   = (MEM_T_RL + 6) / 2;

	// Bit k of each strobe history is the sample taken k edges ago
	logic [31:0]          en_hist;
	logic [31:0]          full_hist;
	rdp_pkg::group_word_t mem [NG][READ_FIFO_DEPTH];
	rdp_pkg::group_word_t word [NG];
	int                   wr_ptr [NG];
	int                   rd_ptr [NG];
	logic [NG-1:0]        reset_q;

	always @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		logic [31:0]                       en_now;
		logic [31:0]                       full_now;
		logic [rdp_pkg::AFI_DATA_WIDTH-1:0] by_slot;
		logic [rdp_pkg::AFI_DATA_WIDTH-1:0] by_group;
		logic                              pop;
		logic                              window;
		int                                lat;
		if (!reset_n_afi_clk)
		begin
			en_hist   = '0;
			full_hist = '0;
			reset_q   = '0;
			for (int g = 0; g < NG; g++)
			begin
				word[g]   = '0;
				wr_ptr[g] = 0;
				rd_ptr[g] = 0;
			end
			exp_rdata_o  <= '0;
			exp_valid_o  <= '0;
			exp_fifo_q_o <= '0;
			exp_oct_o    <= '0;
		end
		else
		begin
			en_now   = {en_hist[30:0], afi_read_req_i.rdata_en[0]};
			full_now = {full_hist[30:0], afi_read_req_i.rdata_en_full[0]};
			lat      = seq_read_ctrl_i.latency_count;
			// Bit d-1 holds the strobe d cycles before the cycle that follows this edge
			pop      = full_now[lat+2];
			window   = 1'b0;
			for (int d = OCT_ON; d <= OCT_OFF; d++)
				window = window | full_now[d-1];
			for (int g = 0; g < NG; g++)
			begin
				// The pop reads memory as it stood before this edge's write
				if (pop)
					word[g] = mem[g][rd_ptr[g]];
				if (seq_read_ctrl_i.fifo_reset[g])
					rd_ptr[g] = 0;
				else if (pop)
					rd_ptr[g] = (rd_ptr[g] + 1) % READ_FIFO_DEPTH;
				mem[g][wr_ptr[g]] = ddio_phy_dq_i[GW*g +: GW];
				wr_ptr[g] = reset_q[g] ? 0 : (wr_ptr[g] + 1) % READ_FIFO_DEPTH;
				by_group[GW*g +: GW] = word[g];
				for (int t = 0; t < rdp_pkg::NUM_TIMESLOTS; t++)
					by_slot[rdp_pkg::MEM_DQ_WIDTH*t + DW*g +: DW] = word[g][DW*t +: DW];
			end
			reset_q   = seq_read_ctrl_i.fifo_reset;
			en_hist   = en_now;
			full_hist = full_now;
			exp_valid_o  <= {rdp_pkg::AFI_RATE_RATIO{en_now[lat+2]}};
			exp_oct_o    <= {NG{~window}};
			exp_rdata_o  <= by_slot;
			exp_fifo_q_o <= by_group;
		end
	end

endmodule

`default_nettype wire

// File: bench/read_datapath_tb.sv
// ******************************
// Testbench for the AFI-clock read datapath
// Runs latency, burst, FIFO reset and OCT tests against a model
// ******************************

`timescale 1ns/1ps
`default_nettype none

module read_datapath_tb;

	// ******************************
	// Test lengths in cycles
	// ******************************

	localparam int NUM_BURSTS     = 24;
	localparam int SETUP_CYCLES   = 5 + 24;
	localparam int SWEEP_CYCLES   = 13 * 23;
	localparam int BURST_CYCLES   = NUM_BURSTS * 6 + 20;
	localparam int RESET_CYCLES   = 2 * 33;
	localparam int OCT_CYCLES     = 60;
	localparam int WATCHDOG_LIMIT =
		SETUP_CYCLES + SWEEP_CYCLES + BURST_CYCLES + RESET_CYCLES + OCT_CYCLES + 200;

	logic                                     pll_afi_clk;
	logic                                     reset_n_afi_clk;
	rdp_pkg::afi_read_req_t                   afi_read_req;
	rdp_pkg::seq_read_ctrl_t                  seq_read_ctrl;
	logic [rdp_pkg::AFI_DATA_WIDTH-1:0]       ddio_phy_dq;
	logic [rdp_pkg::AFI_DATA_WIDTH-1:0]       afi_rdata;
	logic [rdp_pkg::AFI_DATA_WIDTH-1:0]       exp_rdata;
	logic [rdp_pkg::AFI_DATA_WIDTH-1:0]       fifo_q;
	logic [rdp_pkg::AFI_DATA_WIDTH-1:0]       exp_fifo_q;
	logic [rdp_pkg::AFI_RATE_RATIO-1:0]       rdata_valid;
	logic [rdp_pkg::AFI_RATE_RATIO-1:0]       exp_valid;
	logic [rdp_pkg::MEM_READ_DQS_WIDTH-1:0]   oct_off;
	logic [rdp_pkg::MEM_READ_DQS_WIDTH-1:0]   exp_oct;
	logic [31:0]                              rng_state;
	string                                    test_name;

	read_datapath read_datapath_i (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.afi_read_req_i        (afi_read_req),
		.seq_read_ctrl_i       (seq_read_ctrl),
		.ddio_phy_dq_i         (ddio_phy_dq),
		.afi_rdata_o           (afi_rdata),
		.afi_rdata_valid_o     (rdata_valid),
		.phy_mux_read_fifo_q_o (fifo_q),
		.force_oct_off_o       (oct_off)
	);

	// Sees the same inputs as the DUT
	rdp_ref_model rdp_ref_model_i (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_read_req_i  (afi_read_req),
		.seq_read_ctrl_i (seq_read_ctrl),
		.ddio_phy_dq_i   (ddio_phy_dq),
		.exp_rdata_o     (exp_rdata),
		.exp_valid_o     (exp_valid),
		.exp_fifo_q_o    (exp_fifo_q),
		.exp_oct_o       (exp_oct)
	);

	always #5 pll_afi_clk = ~pll_afi_clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state ^ (state << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic report_mismatch(input string what,
		input logic [rdp_pkg::AFI_DATA_WIDTH-1:0] expected,
		input logic [rdp_pkg::AFI_DATA_WIDTH-1:0] actual);
		$display("CHECKS FAILED");
		$display("Mismatch in %s on %s: expected %h, actual %h", test_name, what,
			expected, actual);
		$fatal(1, "Stopping at the first failing check");
	endtask

	// ******************************
	// Output checks
	// ******************************

	valid_check: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		rdata_valid === exp_valid)
		else report_mismatch("afi_rdata_valid_o", $sampled(exp_valid), $sampled(rdata_valid));
	rdata_check: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata === exp_rdata)
		else report_mismatch("afi_rdata_o", $sampled(exp_rdata), $sampled(afi_rdata));
	fifo_q_check: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		fifo_q === exp_fifo_q)
		else report_mismatch("phy_mux_read_fifo_q_o", $sampled(exp_fifo_q), $sampled(fifo_q));
	oct_check: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		oct_off === exp_oct)
		else report_mismatch("force_oct_off_o", $sampled(exp_oct), $sampled(oct_off));

	// Drives one clock of stimulus with fresh DDIO data
	// Phase 1 of each strobe carries random bits that the datapath must ignore
	task automatic drive_cycle(input logic en, input logic full);
		@(posedge pll_afi_clk);
		rng_state = xorshift32(rng_state);
		ddio_phy_dq                <= rng_state;
		afi_read_req.rdata_en      <= {rng_state[31], en};
		afi_read_req.rdata_en_full <= {rng_state[30], full};
	endtask

	task automatic run_idle(input int cycles);
		repeat (cycles) drive_cycle(1'b0, 1'b0);
	endtask

	// Pulses a fifo_reset on one group, then pops a run of words
	task automatic reset_group(input int grp);
		seq_read_ctrl.fifo_reset <= 2'b01 << grp;
		run_idle(3);
		seq_read_ctrl.fifo_reset <= '0;
		run_idle(2);
		repeat (8) drive_cycle(1'b1, 1'b1);
		run_idle(20);
	endtask

	initial
	begin
		int burst_len;
		int gap_len;
		pll_afi_clk     = 1'b0;
		reset_n_afi_clk = 1'b0;
		afi_read_req    = '0;
		seq_read_ctrl   = '0;
		ddio_phy_dq     = '0;
		rng_state       = 32'h7d24;
		test_name       = "reset";
		run_idle(5);
		reset_n_afi_clk <= 1'b1;
		// Fill every FIFO entry before the first pop
		run_idle(24);

		test_name = "latency_sweep";
		for (int lat = 0; lat <= 12; lat++)
		begin
			seq_read_ctrl.latency_count <= lat[rdp_pkg::LATENCY_COUNT_WIDTH-1:0];
			run_idle(2);
			drive_cycle(1'b1, 1'b1);
			run_idle(20);
		end

		// Gaps of zero give back-to-back bursts
		test_name = "random_bursts";
		seq_read_ctrl.latency_count <= 5;
		for (int b = 0; b < NUM_BURSTS; b++)
		begin
			rng_state = xorshift32(rng_state);
			burst_len = 1 + rng_state[1:0];
			gap_len   = rng_state[3:2] % 3;
			repeat (burst_len) drive_cycle(1'b1, 1'b1);
			run_idle(gap_len);
		end
		run_idle(20);

		test_name = "fifo_reset";
		seq_read_ctrl.latency_count <= 4;
		reset_group(0);
		reset_group(1);

		test_name = "oct_window";
		drive_cycle(1'b0, 1'b1);
		run_idle(15);
		repeat (2) drive_cycle(1'b0, 1'b1);
		run_idle(15);
		drive_cycle(1'b0, 1'b1);
		run_idle(3);
		drive_cycle(1'b0, 1'b1);
		run_idle(15);

		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_LIMIT) @(posedge pll_afi_clk);
		$display("CHECKS FAILED");
		$fatal(1, "Timeout: the test sequence did not finish within %0d cycles",
			WATCHDOG_LIMIT);
	end

endmodule

`default_nettype wire

// File: hw/oct_window_timer.sv
// ******************************
// Turns termination off around each read burst
// force_oct_off_o drops while a recent full read strobe
// falls inside the OCT window derived from the read latency
// ******************************

`timescale 1ns/1ps
`default_nettype none

module oct_window_timer #(
	parameter int MEM_T_RL = 11
) (
	input  wire                                       pll_afi_clk,
	input  wire                                       reset_n_afi_clk,
	input  wire                                       rdata_en_full_i,
	output logic [rdp_pkg::MEM_READ_DQS_WIDTH-1:0]    force_oct_off_o
);

	// Window edges in AFI cycles after the strobe
	localparam int OCT_ON_DELAY  = (MEM_T_RL - 4) / 2;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

	// Bit j of the history holds the strobe from j+1 cycles back
	logic [OCT_OFF_DELAY-2:0] rdata_en_hist;

	// The current strobe sits below its history so bit i is the strobe from i cycles back
	logic [OCT_OFF_DELAY-1:0] rdata_en_taps;

	assign rdata_en_taps = {rdata_en_hist, rdata_en_full_i};

	// The output register adds one cycle, so the taps sit one short of the window
	// Output in cycle n is low for any strobe in cycles n-OFF to n-ON
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_hist   <= '0;
			force_oct_off_o <= '0;
		end
		else
		begin
			rdata_en_hist   <= rdata_en_taps[OCT_OFF_DELAY-2:0];
			// All groups share one read window
			force_oct_off_o <= {rdp_pkg::MEM_READ_DQS_WIDTH{
				~(|rdata_en_taps[OCT_OFF_DELAY-1:OCT_ON_DELAY-1])}};
		end
	end

endmodule

`default_nettype wire

// File: hw/rdp_pkg.sv
// ******************************
// Shared widths and bundles for the AFI-side read datapath
// Referenced by scoped name from the RTL and the testbench
// ******************************

`default_nettype none

package rdp_pkg;

	// ******************************
	// Memory interface geometry
	// ******************************

	// Total DQ pins on the memory side
	localparam int MEM_DQ_WIDTH = 8;

	// One read DQS strobe per DQ group
	localparam int MEM_READ_DQS_WIDTH = 2;

	// Half rate controller, so each AFI cycle carries two phases
	localparam int AFI_RATE_RATIO = 2;

	// DDR gives two beats per phase
	localparam int NUM_TIMESLOTS = 2 * AFI_RATE_RATIO;

	// ******************************
	// Derived data widths
	// ******************************

	// DQ pins owned by a single DQS group
	localparam int DQ_GROUP_WIDTH = MEM_DQ_WIDTH / MEM_READ_DQS_WIDTH;

	// A full AFI read word holds all beats of all pins
	localparam int AFI_DATA_WIDTH = MEM_DQ_WIDTH * NUM_TIMESLOTS;

	// All beats of one group, which is also one read FIFO word
	localparam int GROUP_DATA_WIDTH = AFI_DATA_WIDTH / MEM_READ_DQS_WIDTH;

	// ******************************
	// Read latency calibration
	// ******************************

	// The sequencer tunes the latency with a count of this width
	localparam int LATENCY_COUNT_WIDTH = 4;

	// Depth of the read-enable delay lines, one stage per count value
	localparam int MAX_READ_LATENCY = 16;

	// Read strobes from the controller, one bit per AFI phase
	typedef struct packed {
		logic [AFI_RATE_RATIO-1:0] rdata_en;
		logic [AFI_RATE_RATIO-1:0] rdata_en_full;
	} afi_read_req_t;

	// Levels held by the sequencer during and after calibration
	typedef struct packed {
		logic [LATENCY_COUNT_WIDTH-1:0] latency_count;
		logic [MEM_READ_DQS_WIDTH-1:0]  fifo_reset;
	} seq_read_ctrl_t;

	// One group's read FIFO word, ordered by time slot
	typedef logic [GROUP_DATA_WIDTH-1:0] group_word_t;

endpackage

`default_nettype wire

// File: hw/read_datapath.sv
// ******************************
// Top of the AFI-clock read datapath
// Delays the read strobes, pops one FIFO per DQS group and
// returns the data by time slot to the controller and by
// group to the sequencer, with the OCT window alongside
// ******************************

`timescale 1ns/1ps
`default_nettype none

module read_datapath #(
	parameter int READ_FIFO_DEPTH = 16,
	parameter int MEM_T_RL        = 11
) (
	input  wire                                        pll_afi_clk,
	input  wire                                        reset_n_afi_clk,
	input  wire rdp_pkg::afi_read_req_t                afi_read_req_i,
	input  wire rdp_pkg::seq_read_ctrl_t               seq_read_ctrl_i,
	input  wire  [rdp_pkg::AFI_DATA_WIDTH-1:0]         ddio_phy_dq_i,
	output wire  [rdp_pkg::AFI_DATA_WIDTH-1:0]         afi_rdata_o,
	output wire  [rdp_pkg::AFI_RATE_RATIO-1:0]         afi_rdata_valid_o,
	output wire  [rdp_pkg::AFI_DATA_WIDTH-1:0]         phy_mux_read_fifo_q_o,
	output wire  [rdp_pkg::MEM_READ_DQS_WIDTH-1:0]     force_oct_off_o
);

	// Pop strobe shared by every group FIFO
	wire read_enable;

	// ******************************
	// Read strobe timing
	// ******************************

	read_latency_shifter read_latency_shifter_i (
		.pll_afi_clk       (pll_afi_clk),
		.reset_n_afi_clk   (reset_n_afi_clk),
		.afi_read_req_i    (afi_read_req_i),
		.latency_count_i   (seq_read_ctrl_i.latency_count),
		.read_enable_o     (read_enable),
		.afi_rdata_valid_o (afi_rdata_valid_o)
	);

	// Termination follows the full read strobe of phase 0
	oct_window_timer #(
		.MEM_T_RL (MEM_T_RL)
	) oct_window_timer_i (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_full_i (afi_read_req_i.rdata_en_full[0]),
		.force_oct_off_o (force_oct_off_o)
	);

	// ******************************
	// Per-group FIFOs and mapping
	// ******************************

	for (genvar grp = 0; grp < rdp_pkg::MEM_READ_DQS_WIDTH; grp++)
	begin : gen_group
		rdp_pkg::group_word_t fifo_word;

		// DDIO data arrives grouped by DQS and ordered by time slot within a group
		read_fifo_group #(
			.READ_FIFO_DEPTH (READ_FIFO_DEPTH)
		) read_fifo_group_i (
			.pll_afi_clk     (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.ddio_group_i    (ddio_phy_dq_i[rdp_pkg::GROUP_DATA_WIDTH*grp +:
				rdp_pkg::GROUP_DATA_WIDTH]),
			.read_enable_i   (read_enable),
			.fifo_reset_i    (seq_read_ctrl_i.fifo_reset[grp]),
			.rdata_o         (fifo_word)
		);

		// The sequencer sees each group's word untouched
		assign phy_mux_read_fifo_q_o[rdp_pkg::GROUP_DATA_WIDTH*grp +:
			rdp_pkg::GROUP_DATA_WIDTH] = fifo_word;

		// The controller wants all pins of a beat side by side
		// so each beat of this group lands inside its time slot
		for (genvar slot = 0; slot < rdp_pkg::NUM_TIMESLOTS; slot++)
		begin : gen_slot
			assign afi_rdata_o[rdp_pkg::MEM_DQ_WIDTH*slot + rdp_pkg::DQ_GROUP_WIDTH*grp +:
				rdp_pkg::DQ_GROUP_WIDTH] =
				fifo_word[rdp_pkg::DQ_GROUP_WIDTH*slot +: rdp_pkg::DQ_GROUP_WIDTH];
		end
	end

endmodule

`default_nettype wire

// File: hw/read_fifo_group.sv
// ******************************
// Read data FIFO for a single DQS group
// Writes one DDIO word every AFI cycle and pops on read_enable_i
// The sequencer restarts both pointers with fifo_reset_i
// ******************************

`timescale 1ns/1ps
`default_nettype none

module read_fifo_group #(
	parameter int READ_FIFO_DEPTH = 16
) (
	input  wire                          pll_afi_clk,
	input  wire                          reset_n_afi_clk,
	input  wire rdp_pkg::group_word_t    ddio_group_i,
	input  wire                          read_enable_i,
	input  wire                          fifo_reset_i,
	output rdp_pkg::group_word_t         rdata_o
);

	// Depth is a power of two so the pointers wrap on their own
	localparam int ADDR_WIDTH = $clog2(READ_FIFO_DEPTH);

	// ******************************
	// Storage and pointers
	// ******************************

	rdp_pkg::group_word_t    fifo_mem [READ_FIFO_DEPTH];

	logic [ADDR_WIDTH-1:0]   wr_ptr;
	logic [ADDR_WIDTH-1:0]   rd_ptr;

	// Registered copy of the sequencer reset for the write side
	logic                    wr_ptr_reset_q;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_ptr_reset_q <= 1'b0;
		end
		else
		begin
			wr_ptr_reset_q <= fifo_reset_i;
		end
	end

	// The DDIO delivers a word every cycle, so the write side never stalls
	// The write pointer stays at zero while the registered flag is set
	// and resumes counting one cycle after fifo_reset_i drops
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_ptr <= '0;
		end
		else if (wr_ptr_reset_q)
		begin
			wr_ptr <= '0;
		end
		else
		begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge pll_afi_clk)
	begin
		fifo_mem[wr_ptr] <= ddio_group_i;
	end

	// Read pointer is cleared directly by the sequencer level
	// Otherwise it steps once per pop
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rd_ptr <= '0;
		end
		else if (fifo_reset_i)
		begin
			rd_ptr <= '0;
		end
		else if (read_enable_i)
		begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// ******************************
	// Output word
	// ******************************

	// A pop loads the word under the read pointer and holds it until the next pop
	// With nothing written yet the word is whatever the memory still holds
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_o <= '0;
		end
		else if (read_enable_i)
		begin
			rdata_o <= fifo_mem[rd_ptr];
		end
	end

endmodule

`default_nettype wire

// File: hw/read_latency_shifter.sv
// ******************************
// Delays the controller read strobes by the calibrated latency
// read_enable_o pops the group FIFOs and afi_rdata_valid_o
// flags the popped word one cycle later
// ******************************

`timescale 1ns/1ps
`default_nettype none

module read_latency_shifter (
	input  wire                                        pll_afi_clk,
	input  wire                                        reset_n_afi_clk,
	input  wire rdp_pkg::afi_read_req_t                afi_read_req_i,
	input  wire  [rdp_pkg::LATENCY_COUNT_WIDTH-1:0]    latency_count_i,
	output logic                                       read_enable_o,
	output logic [rdp_pkg::AFI_RATE_RATIO-1:0]         afi_rdata_valid_o
);

	// ******************************
	// Delay lines
	// ******************************

	// Stage i holds the phase 0 strobe sampled i+1 cycles ago
	logic [rdp_pkg::MAX_READ_LATENCY-1:0] rdata_en_shift;
	logic [rdp_pkg::MAX_READ_LATENCY-1:0] rdata_en_full_shift;

	// Tap of the valid line registered once, ahead of the output stage
	logic                                 rdata_valid_q;

	// Only phase 0 feeds the lines
	// A half rate read always starts on phase 0, so phase 1 adds nothing
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_shift      <= '0;
			rdata_en_full_shift <= '0;
		end
		else
		begin
			rdata_en_shift      <= {rdata_en_shift[rdp_pkg::MAX_READ_LATENCY-2:0],
				afi_read_req_i.rdata_en[0]};
			rdata_en_full_shift <= {rdata_en_full_shift[rdp_pkg::MAX_READ_LATENCY-2:0],
				afi_read_req_i.rdata_en_full[0]};
		end
	end

	// ******************************
	// Tap selection
	// ******************************

	// A strobe in cycle 0 reaches tap L in cycle L+1
	// The FIFO pop strobe is registered from that tap, so it fires in cycle L+2
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			read_enable_o <= 1'b0;
		end
		else
		begin
			read_enable_o <= rdata_en_full_shift[latency_count_i];
		end
	end

	// The valid path takes one more stage than the pop strobe
	// It therefore rises in cycle L+3, when the popped word sits on the FIFO outputs
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_valid_q     <= 1'b0;
			afi_rdata_valid_o <= '0;
		end
		else
		begin
			rdata_valid_q     <= rdata_en_shift[latency_count_i];
			// Both phases of the word arrive together, so both bits follow phase 0
			afi_rdata_valid_o <= {rdp_pkg::AFI_RATE_RATIO{rdata_valid_q}};
		end
	end

endmodule

`default_nettype wire

// File: list.f
hw/rdp_pkg.sv
hw/read_latency_shifter.sv
hw/read_fifo_group.sv
hw/oct_window_timer.sv
hw/read_datapath.sv
bench/rdp_ref_model.sv
bench/read_datapath_tb.sv
